// File: Makefile
TOP := tb_eeprom_ctrl

.PHONY: all build lint clean

all: build
	./obj_dir/V$(TOP) +verilator+error+limit+10

build:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		-f vlog.f --top-module $(TOP) -Mdir obj_dir

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ns \
		-f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: logic/byte_shifter.sv
// i2c byte shifter
// moves one byte out on sda or in from sda, ninth bit is the ack slot
module byte_shifter
    import i2c_bus_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       phase_strobe,
    input  bus_phase_t phase,
    input  logic       load,
    // 0 send, 1 receive
    input  logic       dir,
    input  byte_t      tx_byte,
    input  logic       master_ack,
    input  logic       sda_in,
    output logic       bit_out,
    output byte_t      rx_byte,
    output logic       ack_seen,
    output logic       byte_done
);

    byte_t      shift_q;
    logic [3:0] bit_cnt;
    logic       busy;
    logic       rx_mode;
    logic       ack_slot;
    logic       low_mid;
    logic       high_mid;

    assign ack_slot = (bit_cnt == 4'd8);
    assign low_mid  = busy && phase_strobe && (phase == PH_LOW_MID);
    assign high_mid = busy && phase_strobe && (phase == PH_HIGH_MID);

    // shift register holds the received byte after eight samples
    assign rx_byte = shift_q;

    // same shift for both directions
    // when sending, the bits coming back in are just our own
    always_ff @(posedge clk) begin
        if (load) begin
            shift_q <= tx_byte;
        end else if (high_mid && !ack_slot) begin
            shift_q <= {shift_q[6:0], sda_in};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            rx_mode   <= 1'b0;
            bit_cnt   <= '0;
            bit_out   <= 1'b1;
            ack_seen  <= 1'b0;
            byte_done <= 1'b0;
        end else begin
            byte_done <= 1'b0;
            if (load) begin
                busy    <= 1'b1;
                rx_mode <= dir;
                bit_cnt <= '0;
            end else if (low_mid) begin
                // 1 means released, the line is open drain
                if (ack_slot) begin
                    bit_out <= rx_mode ? ~master_ack : 1'b1;
                end else begin
                    bit_out <= rx_mode ? 1'b1 : shift_q[7];
                end
            end else if (high_mid) begin
                if (ack_slot) begin
                    busy      <= 1'b0;
                    byte_done <= 1'b1;
                    // slave ack, meaningless for received bytes
                    ack_seen  <= ~sda_in;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
        end
    end

endmodule

// File: logic/eeprom_ctrl_top.sv
// i2c eeprom controller top level
// key driven write and read of a 24lc64, open drain sda pad
module eeprom_ctrl_top
    import i2c_bus_pkg::*;
    import eeprom_pkg::*;
#(
    parameter int QUARTER_CYCLES = 32
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       key_wr,
    input  logic       key_rd,
    input  wr_data_t   data_in,
    output logic       scl,
    inout  wire        sda,
    output logic       led,
    output rd_result_t result,
    output logic       result_valid,
    output logic       ack_error
);

    logic       run;
    logic       phase_strobe;
    bus_phase_t phase;
    logic       wr_req;
    logic       rd_req;
    logic       done;
    logic       load;
    logic       dir;
    byte_t      tx_byte;
    logic       master_ack;
    logic       bit_out;
    byte_t      rx_byte;
    logic       ack_seen;
    logic       byte_done;
    logic       sda_oe;
    logic       sda_out;

    // open drain, a high level is only ever the pull-up
    assign sda = (sda_oe && !sda_out) ? 1'b0 : 1'bz;

    scl_phase_gen #(
        .QUARTER_CYCLES(QUARTER_CYCLES)
    ) scl_phase_gen_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .run         (run),
        .scl         (scl),
        .phase_strobe(phase_strobe),
        .phase       (phase)
    );

    key_cmd_reg key_cmd_reg_i (
        .clk   (clk),
        .rst_n (rst_n),
        .key_wr(key_wr),
        .key_rd(key_rd),
        .done  (done),
        .wr_req(wr_req),
        .rd_req(rd_req)
    );

    byte_shifter byte_shifter_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .phase_strobe(phase_strobe),
        .phase       (phase),
        .load        (load),
        .dir         (dir),
        .tx_byte     (tx_byte),
        .master_ack  (master_ack),
        .sda_in      (sda),
        .bit_out     (bit_out),
        .rx_byte     (rx_byte),
        .ack_seen    (ack_seen),
        .byte_done   (byte_done)
    );

    eeprom_sequencer eeprom_sequencer_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .phase_strobe(phase_strobe),
        .phase       (phase),
        .wr_req      (wr_req),
        .rd_req      (rd_req),
        .wr_data     (data_in),
        .byte_done   (byte_done),
        .ack_seen    (ack_seen),
        .rx_byte     (rx_byte),
        .bit_out     (bit_out),
        .load        (load),
        .dir         (dir),
        .tx_byte     (tx_byte),
        .master_ack  (master_ack),
        .run         (run),
        .sda_oe      (sda_oe),
        .sda_out     (sda_out),
        .done        (done),
        .led         (led),
        .result      (result),
        .result_valid(result_valid),
        .ack_error   (ack_error)
    );

endmodule

// File: logic/eeprom_pkg.sv
// eeprom transfer definitions
// word address, transfer length, payload types and sequencer states
package eeprom_pkg;

    // 64 kbit part, two address bytes
    typedef logic [15:0] word_addr_t;

    // every transfer goes to this location
    localparam word_addr_t EEPROM_ADDR = 16'h0005;

    // data bytes per transfer
    localparam int XFER_BYTES = 3;

    // low byte goes out first, high byte second
    typedef logic [15:0] wr_data_t;

    // first byte read lands in the low byte
    typedef logic [23:0] rd_result_t;

    typedef enum logic [4:0] {
        ST_IDLE    = 5'd0,
        ST_START   = 5'd1,
        ST_CTRL_WR = 5'd2,
        ST_ADDR_HI = 5'd3,
        ST_ADDR_LO = 5'd4,
        ST_WR_DATA = 5'd5,
        ST_RESTART = 5'd6,
        ST_CTRL_RD = 5'd7,
        ST_RD_DATA = 5'd8,
        ST_STOP    = 5'd9,
        ST_DONE    = 5'd10
    } seq_state_t;

endpackage

// File: logic/eeprom_sequencer.sv
// eeprom transfer sequencer
// random write of three bytes or random read of three bytes at a fixed address
module eeprom_sequencer
    import i2c_bus_pkg::*;
    import eeprom_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       phase_strobe,
    input  bus_phase_t phase,
    input  logic       wr_req,
    input  logic       rd_req,
    input  wr_data_t   wr_data,
    input  logic       byte_done,
    input  logic       ack_seen,
    input  byte_t      rx_byte,
    input  logic       bit_out,
    output logic       load,
    output logic       dir,
    output byte_t      tx_byte,
    output logic       master_ack,
    output logic       run,
    output logic       sda_oe,
    output logic       sda_out,
    output logic       done,
    output logic       led,
    output rd_result_t result,
    output logic       result_valid,
    output logic       ack_error
);

    seq_state_t state;
    logic       low_mid;
    logic       high_mid;
    logic       in_byte;
    logic       send_byte;
    logic       last_byte;
    // own sda level for start, restart and stop
    logic       line_q;
    // sda follows the shifter while set
    logic       drive_shift;
    logic [1:0] byte_idx;
    wr_data_t   wr_data_q;

    // third write byte is a checksum of the first two
    function automatic byte_t wr_byte(input logic [1:0] idx, input wr_data_t d);
        case (idx)
            2'd0:    wr_byte = d[7:0];
            2'd1:    wr_byte = d[15:8];
            default: wr_byte = byte_t'(d[7:0] + d[15:8]);
        endcase
    endfunction

    assign low_mid   = phase_strobe && (phase == PH_LOW_MID);
    assign high_mid  = phase_strobe && (phase == PH_HIGH_MID);
    assign in_byte   = state inside {ST_CTRL_WR, ST_ADDR_HI, ST_ADDR_LO,
                                     ST_WR_DATA, ST_CTRL_RD, ST_RD_DATA};
    // bytes whose ack slot belongs to the slave
    assign send_byte = in_byte && (state != ST_RD_DATA);
    assign last_byte = (byte_idx == 2'(XFER_BYTES - 1));
    assign sda_out   = drive_shift ? bit_out : line_q;
    assign done      = (state == ST_DONE);

    // write payload frozen for the whole transfer
    always_ff @(posedge clk) begin
        if (state == ST_IDLE) begin
            wr_data_q <= wr_data;
        end
    end

    // hand sda over only while scl is low
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            drive_shift <= 1'b0;
        end else if (low_mid) begin
            drive_shift <= in_byte;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= ST_IDLE;
            run          <= 1'b0;
            sda_oe       <= 1'b0;
            line_q       <= 1'b1;
            load         <= 1'b0;
            dir          <= 1'b0;
            tx_byte      <= '0;
            master_ack   <= 1'b0;
            byte_idx     <= '0;
            led          <= 1'b1;
            result       <= '0;
            result_valid <= 1'b0;
            ack_error    <= 1'b0;
        end else begin
            load         <= 1'b0;
            result_valid <= 1'b0;
            if (byte_done && send_byte && !ack_seen) begin
                // nack, abort with a stop
                ack_error <= 1'b1;
                state     <= ST_STOP;
            end else begin
                case (state)
                    ST_IDLE: begin
                        line_q <= 1'b1;
                        if (wr_req || rd_req) begin
                            run       <= 1'b1;
                            sda_oe    <= 1'b1;
                            ack_error <= 1'b0;
                            state     <= ST_START;
                        end
                    end
                    ST_START: begin
                        // sda falls while scl is high
                        if (high_mid) begin
                            line_q  <= 1'b0;
                            load    <= 1'b1;
                            dir     <= 1'b0;
                            tx_byte <= I2C_CTRL_WR;
                            state   <= ST_CTRL_WR;
                        end
                    end
                    ST_CTRL_WR: begin
                        if (byte_done) begin
                            load    <= 1'b1;
                            tx_byte <= EEPROM_ADDR[15:8];
                            state   <= ST_ADDR_HI;
                        end
                    end
                    ST_ADDR_HI: begin
                        if (byte_done) begin
                            load    <= 1'b1;
                            tx_byte <= EEPROM_ADDR[7:0];
                            state   <= ST_ADDR_LO;
                        end
                    end
                    ST_ADDR_LO: begin
                        // address written, reads turn around here
                        if (byte_done && rd_req) begin
                            state <= ST_RESTART;
                        end else if (byte_done) begin
                            load     <= 1'b1;
                            tx_byte  <= wr_byte(2'd0, wr_data_q);
                            byte_idx <= '0;
                            state    <= ST_WR_DATA;
                        end
                    end
                    ST_WR_DATA: begin
                        if (byte_done && last_byte) begin
                            state <= ST_STOP;
                        end else if (byte_done) begin
                            load     <= 1'b1;
                            tx_byte  <= wr_byte(byte_idx + 2'd1, wr_data_q);
                            byte_idx <= byte_idx + 2'd1;
                        end
                    end
                    ST_RESTART: begin
                        // release high in the low half, then start again
                        if (low_mid) begin
                            line_q <= 1'b1;
                        end else if (high_mid) begin
                            line_q  <= 1'b0;
                            load    <= 1'b1;
                            tx_byte <= I2C_CTRL_RD;
                            state   <= ST_CTRL_RD;
                        end
                    end
                    ST_CTRL_RD: begin
                        if (byte_done) begin
                            load       <= 1'b1;
                            dir        <= 1'b1;
                            master_ack <= (XFER_BYTES > 1);
                            byte_idx   <= '0;
                            state      <= ST_RD_DATA;
                        end
                    end
                    ST_RD_DATA: begin
                        if (byte_done) begin
                            result[8*byte_idx +: 8] <= rx_byte;
                            if (last_byte) begin
                                state <= ST_STOP;
                            end else begin
                                // nack only the final byte
                                load       <= 1'b1;
                                master_ack <= (byte_idx != 2'(XFER_BYTES - 2));
                                byte_idx   <= byte_idx + 2'd1;
                            end
                        end
                    end
                    ST_STOP: begin
                        // low while scl low, rising while scl high
                        if (low_mid) begin
                            line_q <= 1'b0;
                        end else if (high_mid) begin
                            line_q <= 1'b1;
                            run    <= 1'b0;
                            state  <= ST_DONE;
                        end
                    end
                    ST_DONE: begin
                        sda_oe <= 1'b0;
                        state  <= ST_IDLE;
                        if (!ack_error && rd_req) begin
                            result_valid <= 1'b1;
                        end else if (!ack_error) begin
                            led <= 1'b0;
                        end
                    end
                    default: begin
                        state <= ST_IDLE;
                    end
                endcase
            end
        end
    end

endmodule

// File: logic/i2c_bus_pkg.sv
// i2c bus definitions
// byte type, device control bytes and the scl quarter phases
package i2c_bus_pkg;

    // one byte on the wire
    typedef logic [7:0] byte_t;

    // 24lc64 device select, chip address pins tied low
    localparam byte_t I2C_CTRL_WR = 8'hA0;
    // same device with the read bit set
    localparam byte_t I2C_CTRL_RD = 8'hA1;

    // quarter of the scl period in which a strobe falls
    // order matters, the generator simply counts through it
    typedef enum logic [1:0] {
        // data may change here
        PH_LOW_MID  = 2'd0,
        // scl goes high
        PH_RISE     = 2'd1,
        // data is sampled here
        PH_HIGH_MID = 2'd2,
        // scl goes low
        PH_FALL     = 2'd3
    } bus_phase_t;

endpackage

// File: logic/key_cmd_reg.sv
// key request register
// turns a key press into one pending read or write request
module key_cmd_reg (
    input  logic clk,
    input  logic rst_n,
    input  logic key_wr,
    input  logic key_rd,
    input  logic done,
    output logic wr_req,
    output logic rd_req
);

    // last key levels, keys idle high
    logic key_wr_q;
    logic key_rd_q;
    logic wr_press;
    logic rd_press;

    // high to low edge only, a held key is one press
    assign wr_press = key_wr_q & ~key_wr;
    assign rd_press = key_rd_q & ~key_rd;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            key_wr_q <= 1'b1;
            key_rd_q <= 1'b1;
            wr_req   <= 1'b0;
            rd_req   <= 1'b0;
        end else begin
            key_wr_q <= key_wr;
            key_rd_q <= key_rd;
            if (done) begin
                wr_req <= 1'b0;
                rd_req <= 1'b0;
            end else if (!wr_req && !rd_req) begin
                // presses while busy are dropped
                // write wins a tie
                wr_req <= wr_press;
                rd_req <= rd_press & ~wr_press;
            end
        end
    end

endmodule

// File: logic/scl_phase_gen.sv
// scl generator
// cuts clk into quarter-period strobes and drives scl from them
module scl_phase_gen
    import i2c_bus_pkg::*;
#(
    parameter int QUARTER_CYCLES = 32
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       run,
    output logic       scl,
    output logic       phase_strobe,
    output bus_phase_t phase
);

    localparam int CNT_W = $clog2(QUARTER_CYCLES + 1);

    logic [CNT_W-1:0] cnt;
    // quarter that the next strobe announces
    bus_phase_t       quarter;
    logic             cnt_wrap;

    assign cnt_wrap = (cnt == CNT_W'(QUARTER_CYCLES - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt          <= '0;
            quarter      <= PH_HIGH_MID;
            scl          <= 1'b1;
            phase_strobe <= 1'b0;
            phase        <= PH_HIGH_MID;
        end else if (!run) begin
            // parked with scl high
            // first strobe after run is high_mid, where the start goes out
            cnt          <= '0;
            quarter      <= PH_HIGH_MID;
            scl          <= 1'b1;
            phase_strobe <= 1'b0;
        end else begin
            phase_strobe <= cnt_wrap;
            if (cnt_wrap) begin
                cnt     <= '0;
                phase   <= quarter;
                quarter <= bus_phase_t'(quarter + 2'd1);
                // scl edges line up with the strobe of the same quarter
                if (quarter == PH_RISE) begin
                    scl <= 1'b1;
                end else if (quarter == PH_FALL) begin
                    scl <= 1'b0;
                end
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

// File: tb/eeprom_ctrl_checker.sv
// assertions on the eeprom controller outputs
// bound into the top level, reads the sequencer state
module eeprom_ctrl_checker
    import eeprom_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input logic       scl,
    input logic       led,
    input logic       result_valid,
    input seq_state_t state
);
    timeunit 1ns;
    timeprecision 1ns;

    // set by a failing assertion
    logic pulse_fail = 1'b0;
    logic led_fail   = 1'b0;
    logic idle_fail  = 1'b0;

    valid_is_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid |=> !result_valid)
    else begin
        pulse_fail = 1'b1;
        $error("result_valid high for more than one cycle");
    end

    // write done indication is sticky
    led_stays_low: assert property (@(posedge clk) disable iff (!rst_n)
        !led |=> !led)
    else begin
        led_fail = 1'b1;
        $error("led went high again");
    end

    scl_high_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (state == ST_IDLE) |-> scl)
    else begin
        idle_fail = 1'b1;
        $error("scl low while the sequencer is idle");
    end

endmodule

bind eeprom_ctrl_top eeprom_ctrl_checker eeprom_ctrl_checker_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .scl         (scl),
    .led         (led),
    .result_valid(result_valid),
    .state       (eeprom_sequencer_i.state)
);

// File: tb/eeprom_model.sv
// behavioral i2c eeprom slave
// 16 bytes of memory, sequential write and read, optional nack of the control byte
module eeprom_model
    import i2c_bus_pkg::*;
    import eeprom_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic scl,
    inout  wire  sda,
    input  logic nack_ctrl,
    output logic stop_seen
);
    timeunit 1ns;
    timeprecision 1ns;

    byte_t      mem [16];
    logic       scl_q;
    logic       sda_q;
    // addressed since the last start
    logic       active;
    // slave drives data, master acks
    logic       sending;
    logic       acked;
    logic       read_req;
    logic       mack;
    logic       drive_low;
    // scl rises seen in the current byte frame
    logic [3:0] nbits;
    // 0 control, 1 addr hi, 2 addr lo, 3 data
    logic [1:0] byte_cnt;
    byte_t      rx_sh;
    byte_t      tx_sh;
    word_addr_t ptr;
    logic       start_cond;
    logic       stop_cond;
    logic       scl_rise;
    logic       scl_fall;

    // open drain, the pull-up makes the high level
    assign sda = drive_low ? 1'b0 : 1'bz;

    assign start_cond = scl && scl_q && sda_q && !sda;
    assign stop_cond  = scl && scl_q && !sda_q && sda;
    assign scl_rise   = scl && !scl_q;
    assign scl_fall   = !scl && scl_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 16; i++) begin
                mem[i] <= '0;
            end
            scl_q     <= 1'b1;
            sda_q     <= 1'b1;
            stop_seen <= 1'b0;
            active    <= 1'b0;
            sending   <= 1'b0;
            acked     <= 1'b0;
            read_req  <= 1'b0;
            mack      <= 1'b0;
            drive_low <= 1'b0;
            nbits     <= '0;
            byte_cnt  <= '0;
            rx_sh     <= '0;
            tx_sh     <= '0;
            ptr       <= '0;
        end else begin
            scl_q     <= scl;
            sda_q     <= sda;
            stop_seen <= stop_cond;
            if (start_cond) begin
                // also a repeated start, pointer is kept
                active    <= 1'b1;
                sending   <= 1'b0;
                nbits     <= '0;
                byte_cnt  <= '0;
                drive_low <= 1'b0;
            end else if (stop_cond) begin
                active    <= 1'b0;
                drive_low <= 1'b0;
            end else if (active && scl_rise) begin
                nbits <= nbits + 4'd1;
                if (!sending && nbits < 4'd8) begin
                    rx_sh <= {rx_sh[6:0], sda};
                end else if (sending && nbits == 4'd8) begin
                    mack <= !sda;
                end
            end else if (active && scl_fall) begin
                if (nbits == 4'd8 && sending) begin
                    // let the master drive its ack
                    drive_low <= 1'b0;
                end else if (nbits == 4'd8) begin
                    acked     <= 1'b1;
                    drive_low <= 1'b1;
                    case (byte_cnt)
                        2'd0: begin
                            read_req <= rx_sh[0];
                            if (nack_ctrl || rx_sh[7:1] != I2C_CTRL_WR[7:1]) begin
                                acked     <= 1'b0;
                                drive_low <= 1'b0;
                            end
                        end
                        2'd1: begin
                            ptr[15:8] <= rx_sh;
                        end
                        2'd2: begin
                            ptr[7:0] <= rx_sh;
                        end
                        default: begin
                            mem[ptr[3:0]] <= rx_sh;
                            ptr           <= ptr + 16'd1;
                        end
                    endcase
                    if (byte_cnt != 2'd3) begin
                        byte_cnt <= byte_cnt + 2'd1;
                    end
                end else if (nbits == 4'd9) begin
                    nbits <= '0;
                    if ((sending && mack) ||
                        (!sending && acked && read_req && byte_cnt == 2'd1)) begin
                        // next read byte, msb out right away
                        sending   <= 1'b1;
                        tx_sh     <= mem[ptr[3:0]];
                        drive_low <= ~mem[ptr[3:0]][7];
                        ptr       <= ptr + 16'd1;
                    end else if (sending || !acked) begin
                        active    <= 1'b0;
                        drive_low <= 1'b0;
                    end else begin
                        drive_low <= 1'b0;
                    end
                end else if (sending && nbits != 4'd0) begin
                    tx_sh     <= {tx_sh[6:0], 1'b0};
                    drive_low <= ~tx_sh[6];
                end
            end
        end
    end

endmodule

// File: tb/tb_eeprom_ctrl.sv
// testbench for the i2c eeprom controller
// random key presses against a behavioral eeprom and a memory image
module tb_eeprom_ctrl
    import i2c_bus_pkg::*;
    import eeprom_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ns;

    localparam int N_TXN       = 24;
    localparam int CYCLE_LIMIT = N_TXN * 2000;
    // quiet window after a transfer with the key still held
    localparam int IDLE_WATCH  = 300;

    logic       clk;
    logic       rst_n;
    logic       key_wr;
    logic       key_rd;
    wr_data_t   data_in;
    logic       scl;
    wire        sda;
    logic       led;
    rd_result_t result;
    logic       result_valid;
    logic       ack_error;
    logic       nack_ctrl;
    logic       stop_seen;

    integer     seed;
    int         cycles = 0;
    int         valid_count = 0;
    rd_result_t valid_data = '0;
    // expected eeprom contents at the fixed address
    byte_t      image [XFER_BYTES];
    logic       led_exp;
    logic       ack_error_exp;

    pullup (sda);

    eeprom_ctrl_top #(
        .QUARTER_CYCLES(4)
    ) eeprom_ctrl_top_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .key_wr      (key_wr),
        .key_rd      (key_rd),
        .data_in     (data_in),
        .scl         (scl),
        .sda         (sda),
        .led         (led),
        .result      (result),
        .result_valid(result_valid),
        .ack_error   (ack_error)
    );

    eeprom_model eeprom_model_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .scl      (scl),
        .sda      (sda),
        .nack_ctrl(nack_ctrl),
        .stop_seen(stop_seen)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1, "run aborted");
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            fail_run($sformatf("timeout, tests not finished after %0d cycles", cycles));
        end
    end

    // failures of the bound assertions
    always @(posedge clk) begin
        if (eeprom_ctrl_top_i.eeprom_ctrl_checker_i.pulse_fail ||
            eeprom_ctrl_top_i.eeprom_ctrl_checker_i.led_fail ||
            eeprom_ctrl_top_i.eeprom_ctrl_checker_i.idle_fail) begin
            fail_run("an assertion in the checker failed");
        end
    end

    always @(posedge clk) begin
        if (result_valid) begin
            valid_count <= valid_count + 1;
            valid_data  <= result;
        end
    end

    task automatic check_result(input rd_result_t got, input rd_result_t exp);
        if (got !== exp) begin
            fail_run($sformatf("error at %0t ns: result %h, expected %h", $time, got, exp));
        end
    endtask

    task automatic check_led(input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("error at %0t ns: led %b, expected %b", $time, got, exp));
        end
    endtask

    task automatic check_ack_error(input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("error at %0t ns: ack_error %b, expected %b", $time, got, exp));
        end
    endtask

    task automatic check_mem(input byte_t got, input byte_t exp, input int idx);
        if (got !== exp) begin
            fail_run($sformatf("error at %0t ns: eeprom byte %0d is %h, expected %h",
                               $time, idx, got, exp));
        end
    endtask

    task automatic check_valid_pulses(input int got, input int exp);
        if (got != exp) begin
            fail_run($sformatf("error at %0t ns: %0d result_valid pulses, expected %0d",
                               $time, got, exp));
        end
    endtask

    task automatic wait_stop();
        do begin
            @(posedge clk);
        end while (!stop_seen);
    endtask

    task automatic run_transfer(input int n);
        logic [31:0] rnd;
        logic        do_write;
        logic        do_nack;
        logic        hold_long;
        int          hold;
        int          count_before;
        wr_data_t    data;
        logic [3:0]  idx;

        rnd       = $random(seed);
        do_write  = rnd[0];
        do_nack   = (rnd[2:1] == 2'd0);
        hold_long = rnd[3];
        hold      = 2 + int'(rnd[5:4]);
        rnd       = $random(seed);
        data      = rnd[15:0];
        if (n == 0) begin
            // blank part is read first
            do_write = 1'b0;
            do_nack  = 1'b0;
        end
        count_before = valid_count;

        @(posedge clk);
        nack_ctrl <= do_nack;
        data_in   <= data;
        if (do_write) begin
            key_wr <= 1'b0;
        end else begin
            key_rd <= 1'b0;
        end
        if (!hold_long) begin
            repeat (hold) @(posedge clk);
            key_wr <= 1'b1;
            key_rd <= 1'b1;
        end
        wait_stop();
        repeat (4) @(posedge clk);

        if (do_nack) begin
            ack_error_exp = 1'b1;
        end else begin
            ack_error_exp = 1'b0;
            if (do_write) begin
                image[0] = data[7:0];
                image[1] = data[15:8];
                image[2] = byte_t'((int'(data[7:0]) + int'(data[15:8])) % 256);
                led_exp  = 1'b0;
            end
        end

        check_led(led, led_exp);
        check_ack_error(ack_error, ack_error_exp);
        for (int i = 0; i < XFER_BYTES; i++) begin
            idx = EEPROM_ADDR[3:0] + 4'(i);
            check_mem(eeprom_model_i.mem[idx], image[i], i);
        end
        if (!do_write && !do_nack) begin
            check_valid_pulses(valid_count - count_before, 1);
            check_result(valid_data, {image[2], image[1], image[0]});
        end else begin
            check_valid_pulses(valid_count - count_before, 0);
        end

        if (hold_long) begin
            // key still pressed so the bus must stay quiet
            repeat (IDLE_WATCH) begin
                @(posedge clk);
                if (!scl) begin
                    fail_run("a held key started a second transfer");
                end
            end
            key_wr <= 1'b1;
            key_rd <= 1'b1;
            @(posedge clk);
        end
    endtask

    initial begin
        seed          = 32'hfe0f;
        rst_n         = 1'b0;
        key_wr        = 1'b1;
        key_rd        = 1'b1;
        data_in       = '0;
        nack_ctrl     = 1'b0;
        led_exp       = 1'b1;
        ack_error_exp = 1'b0;
        for (int i = 0; i < XFER_BYTES; i++) begin
            image[i] = '0;
        end
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_led(led, 1'b1);
        check_ack_error(ack_error, 1'b0);
        for (int n = 0; n < N_TXN; n++) begin
            run_transfer(n);
        end
        $display("sim passed");
        $finish;
    end

endmodule

// File: vlog.f
logic/i2c_bus_pkg.sv
logic/eeprom_pkg.sv
logic/scl_phase_gen.sv
logic/key_cmd_reg.sv
logic/byte_shifter.sv
logic/eeprom_sequencer.sv
logic/eeprom_ctrl_top.sv
tb/eeprom_model.sv
tb/eeprom_ctrl_checker.sv
tb/tb_eeprom_ctrl.sv
